// ==== all.f ====
hdl/sdram_pkg.sv
hdl/req_fifo.sv
hdl/sdram_ctrl.sv
hdl/read_return.sv
hdl/sdram_top.sv
sim/sdram_model.sv
sim/tb_top.sv

// ==== hdl/read_return.sv ====
// Read data return path
`default_nettype none

module read_return (
	input  logic                clk,
	input  logic                n_reset,
	input  sdram_pkg::rd_tag_t  rd_tag,
	input  logic [31:0]         dq_in,
	output logic                rsp_valid,
	output sdram_pkg::mem_rsp_t rsp
);
	import sdram_pkg::*;

	rd_tag_t tag_sr [CAS_LATENCY];   // Tags in flight
	rd_tag_t tag_out;

	assign tag_out = tag_sr[CAS_LATENCY-1];   // Data on dq_in this cycle

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < CAS_LATENCY; i++) begin
				tag_sr[i] <= '0;
			end
			rsp_valid <= 1'b0;
		end else begin
			tag_sr[0] <= rd_tag;
			for (int i = 1; i < CAS_LATENCY; i++) begin
				tag_sr[i] <= tag_sr[i-1];
			end
			rsp_valid <= tag_out.rd;
		end
	end

	// Lane select, registered with rsp_valid
	always_ff @(posedge clk) begin
		if (tag_out.rd) begin
			rsp.rdata <= dq_in[{tag_out.byte_sel, 3'b000} +: 8];
		end
	end

	// Reads are spaced by a full access, so responses never touch
	a_rsp_single: assert property (@(posedge clk) disable iff (!n_reset)
		rsp_valid |=> !rsp_valid);

endmodule

`default_nettype wire

// ==== hdl/req_fifo.sv ====
// Request buffer
`default_nettype none

module req_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                clk,
	input  logic                n_reset,
	input  logic                in_valid,
	output logic                in_ready,
	input  sdram_pkg::mem_req_t in_data,
	output logic                out_valid,
	input  logic                out_ready,
	output sdram_pkg::mem_req_t out_data
);
	import sdram_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_req_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;   // Entries held
	logic             full;
	logic             push;
	logic             pop;

	// Wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full      = (count == CNT_W'(DEPTH));
	assign in_ready  = !full;
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];   // Head of queue
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;          // Idle or pass-through
			endcase
		end
	end

	// A push never lands on an unread entry
	a_no_push_full: assert property (@(posedge clk) disable iff (!n_reset)
		push && count != '0 |-> wr_ptr != rd_ptr);

	// Head entry holds while the consumer stalls
	a_hold_head: assert property (@(posedge clk) disable iff (!n_reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== hdl/sdram_ctrl.sv ====
// SDRAM command sequencer
`default_nettype none

module sdram_ctrl #(
	parameter int FREQ_HZ = 10_000_000
) (
	input  logic                   clk,
	input  logic                   n_reset,
	input  logic                   q_valid,
	output logic                   q_ready,
	input  sdram_pkg::mem_req_t    q,
	output sdram_pkg::sdram_pins_t pins,
	output sdram_pkg::rd_tag_t     rd_tag
);
	import sdram_pkg::*;

	localparam int CLOCK_NS      = 1_000_000_000 / FREQ_HZ;
	localparam int INIT_COUNT    = INIT_WAIT_NS / CLOCK_NS;   // Clocks
	localparam int INIT_W        = $clog2(INIT_COUNT + 1);
	localparam int REFRESH_COUNT = REFRESH_NS / CLOCK_NS;     // Clocks
	localparam int REF_W         = $clog2(REFRESH_COUNT + 1);
	// A10 0, single write burst 0, mode 00, CL 010, seq 0, BL 000
	localparam logic [10:0] MODE_VALUE = 11'b000_0010_0000;

	ctrl_state_e       state;
	ctrl_state_e       ret_state;   // Where ST_WAIT goes next
	logic [1:0]        wait_cnt;    // Extra NOPs left
	logic [INIT_W-1:0] init_timer;
	logic              init_done;
	logic [REF_W-1:0]  ref_timer;
	logic              ref_due;
	logic              accept;
	logic              req_write;   // Latched request
	logic [7:0]        req_col;
	logic [1:0]        req_byte;

	assign q_ready = (state == ST_IDLE);
	assign accept  = q_valid && q_ready;

	// ------------------------------------------------------------
	// Power-up and refresh timers
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			init_timer <= '0;
		end else if (!init_done) begin
			init_timer <= init_timer + 1'b1;
		end
	end
	assign init_done = (init_timer == INIT_W'(INIT_COUNT));

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ref_timer <= '0;
		end else if (accept || (state == ST_IDLE && ref_due)) begin
			ref_timer <= '0;                   // Access or refresh restarts it
		end else if (!ref_due) begin
			ref_timer <= ref_timer + 1'b1;     // Saturates at the interval
		end
	end
	assign ref_due = (ref_timer == REF_W'(REFRESH_COUNT));

	// ------------------------------------------------------------
	// Command FSM, pins registered
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state      <= ST_INIT_WAIT;
			ret_state  <= ST_IDLE;
			wait_cnt   <= '0;
			pins.cmd   <= CMD_NOP;
			pins.ba    <= '0;
			pins.addr  <= '0;
			pins.dqm   <= 4'b1111;   // All lanes masked
			pins.dq_oe <= 1'b0;
			rd_tag     <= '0;
		end else begin
			pins.cmd   <= CMD_NOP;
			pins.dq_oe <= 1'b0;
			rd_tag     <= '0;
			case (state)
			ST_INIT_WAIT: begin
				if (init_done) begin
					state     <= ST_INIT_PRECHARGE;
					pins.cmd  <= CMD_PRECHARGE;
					pins.addr <= 11'b100_0000_0000;   // A10 high, all banks
				end
			end
			ST_INIT_PRECHARGE: begin
				state    <= ST_INIT_REFRESH1;
				pins.cmd <= CMD_AUTO_REFRESH;
			end
			ST_INIT_REFRESH1: begin
				state     <= ST_WAIT;
				ret_state <= ST_INIT_REFRESH2;
				wait_cnt  <= 2'd2;
			end
			ST_INIT_REFRESH2: begin
				state     <= ST_WAIT;
				ret_state <= ST_MODE_LOAD;
				wait_cnt  <= 2'd2;
			end
			ST_MODE_LOAD: begin
				state     <= ST_WAIT;
				ret_state <= ST_IDLE;
				wait_cnt  <= 2'd1;                  // tMRD
			end
			ST_IDLE: begin
				if (accept) begin
					state       <= ST_WAIT;
					ret_state   <= ST_ACCESS_CMD;
					wait_cnt    <= 2'd3;            // tRCD
					pins.cmd    <= CMD_ACTIVE;
					pins.ba     <= q.addr[22:21];
					pins.addr   <= q.addr[20:10];   // Row
					pins.dqm    <= q.write ? ~(4'b0001 << q.addr[1:0]) : 4'b0000;
					pins.dq_out <= {4{q.wdata}};    // Same byte on every lane
					req_write   <= q.write;
					req_col     <= q.addr[9:2];
					req_byte    <= q.addr[1:0];
				end else if (ref_due) begin
					state    <= ST_ACCESS_REFRESH;
					pins.cmd <= CMD_AUTO_REFRESH;
				end
			end
			ST_ACCESS_CMD: begin
				if (req_write) begin
					state     <= ST_WAIT;           // tWR, one NOP
					ret_state <= ST_ACCESS_PRECHARGE;
					wait_cnt  <= '0;
				end else begin
					state         <= ST_ACCESS_PRECHARGE;
					pins.cmd      <= CMD_PRECHARGE;
					pins.addr[10] <= 1'b1;
				end
			end
			ST_ACCESS_PRECHARGE: begin
				state     <= ST_WAIT;
				ret_state <= ST_ACCESS_REFRESH;
				wait_cnt  <= '0;
			end
			ST_ACCESS_REFRESH: begin
				state     <= ST_WAIT;
				ret_state <= ST_IDLE;
				wait_cnt  <= 2'd2;
				pins.dqm  <= 4'b1111;
			end
			ST_WAIT: begin
				if (wait_cnt != '0) begin
					wait_cnt <= wait_cnt - 1'b1;
				end else begin
					state <= ret_state;
					// Command that opens the return state
					case (ret_state)
					ST_INIT_REFRESH2, ST_ACCESS_REFRESH: pins.cmd <= CMD_AUTO_REFRESH;
					ST_MODE_LOAD: begin
						pins.cmd  <= CMD_LOAD_MODE;
						pins.addr <= MODE_VALUE;
					end
					ST_ACCESS_CMD: begin
						pins.cmd        <= req_write ? CMD_WRITE : CMD_READ;
						pins.addr       <= {3'b000, req_col};   // A10 low, no auto precharge
						pins.dq_oe      <= req_write;
						rd_tag.rd       <= !req_write;
						rd_tag.byte_sel <= req_byte;
					end
					ST_ACCESS_PRECHARGE: begin
						pins.cmd      <= CMD_PRECHARGE;
						pins.addr[10] <= 1'b1;
					end
					default: pins.cmd <= CMD_NOP;
					endcase
				end
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	// Bus driven only for a WRITE with one lane open
	a_oe_write: assert property (@(posedge clk) disable iff (!n_reset)
		pins.dq_oe |-> pins.cmd == CMD_WRITE && $onehot(~pins.dqm));

	// No host traffic before the init sequence ran
	a_ready_init: assert property (@(posedge clk) disable iff (!n_reset)
		q_ready |-> init_done);

endmodule

`default_nettype wire

// ==== hdl/sdram_pkg.sv ====
// SDRAM controller shared types
`default_nettype none

package sdram_pkg;

	// ------------------------------------------------------------
	// Sizes and timing
	// ------------------------------------------------------------
	localparam int ADDR_W       = 23;       // Byte address, 8 MB
	localparam int CAS_LATENCY  = 2;        // Read latency in clocks
	localparam int INIT_WAIT_NS = 120_000;  // Power-up wait
	localparam int REFRESH_NS   = 15_000;   // Refresh interval

	// Command encoding {ras_n, cas_n, we_n}, cs_n tied low on board
	typedef enum logic [2:0] {
		CMD_LOAD_MODE    = 3'b000,
		CMD_AUTO_REFRESH = 3'b001,
		CMD_PRECHARGE    = 3'b010,
		CMD_ACTIVE       = 3'b011,
		CMD_WRITE        = 3'b100,
		CMD_READ         = 3'b101,
		CMD_NOP          = 3'b111
	} sdram_cmd_e;

	// Controller FSM states
	typedef enum logic [3:0] {
		ST_INIT_WAIT,         // Power-up timer
		ST_INIT_PRECHARGE,
		ST_INIT_REFRESH1,
		ST_INIT_REFRESH2,
		ST_MODE_LOAD,
		ST_IDLE,
		ST_ACCESS_CMD,        // READ or WRITE on pins
		ST_ACCESS_PRECHARGE,
		ST_ACCESS_REFRESH,
		ST_WAIT               // Counted NOPs, then ret_state
	} ctrl_state_e;

	// ------------------------------------------------------------
	// Bundles
	// ------------------------------------------------------------
	typedef struct packed {
		logic              write;  // 1 = write, 0 = read
		logic [ADDR_W-1:0] addr;   // Byte address
		logic [7:0]        wdata;
	} mem_req_t;

	typedef struct packed {
		logic [7:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		sdram_cmd_e  cmd;
		logic [1:0]  ba;
		logic [10:0] addr;    // Row or column
		logic [3:0]  dqm;     // High masks a lane
		logic [31:0] dq_out;
		logic        dq_oe;   // Drive dq_out onto the bus
	} sdram_pins_t;

	typedef struct packed {
		logic       rd;        // READ went out
		logic [1:0] byte_sel;  // Lane to return
	} rd_tag_t;

endpackage

`default_nettype wire

// ==== hdl/sdram_top.sv ====
// SDRAM subsystem top
`default_nettype none

module sdram_top #(
	parameter int FREQ_HZ    = 10_000_000,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   n_reset,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  sdram_pkg::mem_req_t    req,
	output logic                   rsp_valid,
	output sdram_pkg::mem_rsp_t    rsp,
	output sdram_pkg::sdram_pins_t pins,
	input  logic [31:0]            dq_in
);
	import sdram_pkg::*;

	logic     q_valid;   // FIFO head to controller
	logic     q_ready;
	mem_req_t q;
	rd_tag_t  rd_tag;    // Controller to read return

	req_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk      (clk),
		.n_reset  (n_reset),
		.in_valid (req_valid),
		.in_ready (req_ready),
		.in_data  (req),
		.out_valid(q_valid),
		.out_ready(q_ready),
		.out_data (q)
	);

	sdram_ctrl #(
		.FREQ_HZ(FREQ_HZ)
	) u_ctrl (
		.clk    (clk),
		.n_reset(n_reset),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q      (q),
		.pins   (pins),
		.rd_tag (rd_tag)
	);

	read_return u_ret (
		.clk      (clk),
		.n_reset  (n_reset),
		.rd_tag   (rd_tag),
		.dq_in    (dq_in),
		.rsp_valid(rsp_valid),
		.rsp      (rsp)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/bash
# Build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_top -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sim/sdram_model.sv ====
// Behavioral SDRAM model
`default_nettype none

module sdram_model (
	input  logic                   clk,
	input  sdram_pkg::sdram_pins_t pins,
	output logic [31:0]            dq_in,
	output int                     illegal_cnt
);
	timeunit 1ns;
	timeprecision 1ns;
	import sdram_pkg::*;

	logic [31:0] mem [logic [20:0]];   // {bank, row, col}
	logic        bank_open [4];
	logic [10:0] open_row [4];
	logic        mode_set;
	logic [31:0] rd_pipe [2];          // CL2 delay line

	initial begin
		for (int i = 0; i < 4; i++) begin
			bank_open[i] = 1'b0;
			open_row[i]  = '0;
		end
		mode_set    = 1'b0;
		illegal_cnt = 0;
		rd_pipe[0]  = '0;
		rd_pipe[1]  = '0;
	end

	assign dq_in = rd_pipe[1];

	// Command decode on the rising edge
	always @(posedge clk) begin
		logic [20:0] key;
		logic [31:0] word;
		key        = {pins.ba, open_row[pins.ba], pins.addr[7:0]};
		word       = mem.exists(key) ? mem[key] : 32'h0;
		rd_pipe[1] <= rd_pipe[0];
		rd_pipe[0] <= 32'hdead_beef;   // Garbage when not reading
		case (pins.cmd)
		CMD_ACTIVE: begin
			if (bank_open[pins.ba] || !mode_set) begin
				illegal_cnt++;
				$display("Model: ACTIVE on open bank or before mode load");
			end
			bank_open[pins.ba] <= 1'b1;
			open_row[pins.ba]  <= pins.addr;
		end
		CMD_READ, CMD_WRITE: begin
			if (!bank_open[pins.ba]) begin
				illegal_cnt++;
				$display("Model: READ or WRITE on closed bank %0d", pins.ba);
			end
			if (pins.cmd == CMD_READ) begin
				rd_pipe[0] <= word;
			end else begin
				for (int i = 0; i < 4; i++) begin
					if (!pins.dqm[i] && pins.dq_oe) begin
						word[i*8 +: 8] = pins.dq_out[i*8 +: 8];   // Unmasked lane
					end
				end
				mem[key] = word;
			end
		end
		CMD_PRECHARGE: begin
			for (int i = 0; i < 4; i++) begin
				if (pins.addr[10] || pins.ba == 2'(i)) begin
					bank_open[i] <= 1'b0;
				end
			end
		end
		CMD_AUTO_REFRESH: begin
			if (bank_open[0] || bank_open[1] || bank_open[2] || bank_open[3]) begin
				illegal_cnt++;
				$display("Model: refresh with a bank open");
			end
		end
		CMD_LOAD_MODE: mode_set <= 1'b1;
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
// SDRAM controller testbench
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 1ns;
	import sdram_pkg::*;

	localparam int REF_LIMIT = 152;   // Refresh interval in clocks plus 2

	logic        clk;
	logic        n_reset;
	logic        req_valid;
	logic        req_ready;
	mem_req_t    req;
	logic        rsp_valid;
	mem_rsp_t    rsp;
	sdram_pins_t pins;
	logic [31:0] dq_in;
	int          illegal_cnt;

	logic [31:0] lfsr;
	logic [7:0]  ref_mem [int];    // Expected memory contents
	logic [7:0]  exp_q [$];        // Reads in flight
	logic [3:0]  dqm_q [$];        // dqm seen on WRITE
	logic        saw_full;

	sdram_top #(.FREQ_HZ(10_000_000), .FIFO_DEPTH(4)) dut0 (
		.clk(clk), .n_reset(n_reset), .req_valid(req_valid), .req_ready(req_ready),
		.req(req), .rsp_valid(rsp_valid), .rsp(rsp), .pins(pins), .dq_in(dq_in)
	);

	sdram_model mem0 (.clk(clk), .pins(pins), .dq_in(dq_in), .illegal_cnt(illegal_cnt));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			fail_run($sformatf("Error %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;   // Galois step
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] ref_read(input logic [ADDR_W-1:0] a);
		return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : 8'h00;
	endfunction

	// Called at a falling edge, returns at one
	task automatic send(input logic wr, input logic [ADDR_W-1:0] a, input logic [7:0] d);
		int t;
		t         = 0;
		req_valid = 1'b1;
		req.write = wr;
		req.addr  = a;
		req.wdata = d;
		if (!req_ready) saw_full = 1'b1;
		while (!req_ready) begin
			@(negedge clk);
			t++;
			if (t > 500) fail_run("Request was never accepted by the FIFO");
		end
		@(negedge clk);
		req_valid = 1'b0;
		if (wr) ref_mem[int'(a)] = d;
		else exp_q.push_back(ref_read(a));
	endtask

	task automatic next_cmd(input int tmo, output sdram_cmd_e c, output int n);
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > tmo) fail_run("No SDRAM command appeared in time");
		end while (pins.cmd == CMD_NOP);
		c = pins.cmd;
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			t++;
			if (t > 3000) fail_run("Read responses stopped arriving");
		end
	endtask

	// Response checker
	initial begin
		forever begin
			@(negedge clk);
			if (rsp_valid) begin
				if (exp_q.size() == 0) fail_run("Response arrived with no read outstanding");
				check("read data", 32'(exp_q.pop_front()), 32'(rsp.rdata));
			end
		end
	end

	always @(negedge clk) begin
		if (pins.cmd == CMD_WRITE) dqm_q.push_back(pins.dqm);
	end

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------
	initial begin
		sdram_cmd_e c;
		int         n;
		logic [3:0] lane_mask [4];
		logic [ADDR_W-1:0] a;
		logic [1:0] rnd_bank;
		logic [5:0] rnd_low;
		logic       rnd_wr;
		logic [7:0] rnd_data;
		lane_mask = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};
		n_reset   = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		lfsr      = 32'hbc2d_8fac;
		saw_full  = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		n_reset = 1'b1;

		// Init, with a write already waiting in the FIFO
		send(1'b1, 23'h2a_5c13, 8'h5a);
		next_cmd(2000, c, n);
		check("init wait done", 1, 32'(n >= 1199));
		check("init precharge", 32'(CMD_PRECHARGE), 32'(c));
		check("precharge all", 1, 32'(pins.addr[10]));
		next_cmd(20, c, n);
		check("init refresh 1", 32'(CMD_AUTO_REFRESH), 32'(c));
		next_cmd(20, c, n);
		check("init refresh 2", 32'(CMD_AUTO_REFRESH), 32'(c));
		next_cmd(20, c, n);
		check("mode load", 32'(CMD_LOAD_MODE), 32'(c));
		check("mode value", 32'h020, 32'(pins.addr));
		next_cmd(20, c, n);
		check("first access", 32'(CMD_ACTIVE), 32'(c));

		// Write then read
		send(1'b0, 23'h2a_5c13, 8'h00);
		drain();

		// Byte lanes
		dqm_q.delete();
		for (int b = 0; b < 4; b++) send(1'b1, 23'h10_4400 + 23'(b), 8'h11 * 8'(b + 1));
		for (int b = 0; b < 4; b++) send(1'b0, 23'h10_4400 + 23'(b), 8'h00);
		drain();
		check("write count", 4, dqm_q.size());
		for (int b = 0; b < 4; b++) check("write dqm", 32'(lane_mask[b]), 32'(dqm_q[b]));

		// Back-pressure with six reads
		saw_full = 1'b0;
		for (int b = 0; b < 6; b++) send(1'b0, (b < 4) ? 23'h10_4400 + 23'(b) : 23'h2a_5c13, 8'h00);
		drain();
		check("req_ready dropped", 1, 32'(saw_full));

		// Idle refresh spacing
		next_cmd(400, c, n);
		check("idle refresh", 32'(CMD_AUTO_REFRESH), 32'(c));
		repeat (2) begin
			next_cmd(400, c, n);
			check("idle refresh", 32'(CMD_AUTO_REFRESH), 32'(c));
			check("refresh spacing", 1, 32'(n <= REF_LIMIT));
		end

		// Random traffic over banks and a few words
		for (int i = 0; i < 200; i++) begin
			rnd_bank = 2'(take_bits(2));
			rnd_low  = 6'(take_bits(6));
			rnd_wr   = 1'(take_bits(1));
			rnd_data = 8'(take_bits(8));
			a        = {rnd_bank, 11'h055, 4'h0, rnd_low};
			send(rnd_wr, a, rnd_data);
		end
		drain();
		check("illegal commands", 0, 32'(illegal_cnt));

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
